//--- thumb_ctrl_cfg.svh
`ifndef THUMB_CTRL_CFG_SVH
`define THUMB_CTRL_CFG_SVH

// datapath word width
`define WORD_W          32

// register file address, r0..r15
`define REG_ADDR_W      4

// register list of the multi-register forms, r0..r7 only
`define LIST_W          8

`define SP_REG_NUM      13

`define BYTES_PER_WORD  4

// wide enough for a beat index or a register count up to LIST_W
`define CNT_W           4

`endif

//--- thumb_isa_pkg.sv
`default_nettype none

`include "thumb_ctrl_cfg.svh"

package thumb_isa_pkg;

    // one representative encoding of bits 15:10 per class
    typedef enum logic [5:0] {
        SHIFT_IMM       = 6'b000000,
        DATA_PROC       = 6'b010000,
        LOAD_STORE_REG  = 6'b010100,
        LOAD_STORE_IMM  = 6'b011000,
        LOAD_STORE_BYTE = 6'b011100,
        LOAD_STORE_HW   = 6'b100000,
        LOAD_STORE_SP_R = 6'b100100,
        MISC_16         = 6'b101100,
        STORE_MULT      = 6'b110000,
        LOAD_MULT       = 6'b110010,
        CLASS_OTHER     = 6'b111111
    } op_class_e;

    // bits 13:9 of the shift/immediate group, low two bits cleared where they hold immediate
    typedef enum logic [4:0] {
        LSL_IMM   = 5'b00000,
        LSR_IMM   = 5'b00100,
        ASR_IMM   = 5'b01000,
        ADD_REG   = 5'b01100,
        SUB_REG   = 5'b01101,
        ADD_3_IMM = 5'b01110,
        SUB_3_IMM = 5'b01111,
        MOV_8_IMM = 5'b10000,
        CMP_8_IMM = 5'b10100,
        ADD_8_IMM = 5'b11000,
        SUB_8_IMM = 5'b11100
    } shift_code_e;

    typedef enum logic [3:0] {
        DP_AND = 4'b0000,
        DP_EOR = 4'b0001,
        DP_LSL = 4'b0010,
        DP_LSR = 4'b0011,
        DP_ASR = 4'b0100,
        DP_ADC = 4'b0101,
        DP_SBC = 4'b0110,
        DP_ROR = 4'b0111,
        DP_TST = 4'b1000,
        DP_RSB = 4'b1001,
        DP_CMP = 4'b1010,
        DP_CMN = 4'b1011,
        DP_ORR = 4'b1100,
        DP_MUL = 4'b1101,
        DP_BIC = 4'b1110,
        DP_MVN = 4'b1111
    } dp_code_e;

    typedef enum logic [6:0] {
        PUSH_REGS  = 7'b0100000,
        POP_REGS   = 7'b1100000,
        MISC_OTHER = 7'b1111111
    } misc_code_e;

    typedef struct packed {
        logic [5:0] op;
        logic [3:0] sub_code;
        logic [2:0] rs;
        logic [2:0] rd;
    } operand_fmt_t;

    typedef struct packed {
        logic [3:0]         cls;
        logic               load;
        logic [2:0]         base;
        logic [`LIST_W-1:0] reg_list;
    } list_fmt_t;

    typedef union packed {
        operand_fmt_t opnd;
        list_fmt_t    lst;
    } thumb_instr_u;

    function automatic op_class_e classify_op(input logic [5:0] op);
        op_class_e cls;
        casez (op)
            6'b00????: cls = SHIFT_IMM;
            6'b010000: cls = DATA_PROC;
            6'b0101??: cls = LOAD_STORE_REG;
            6'b0110??: cls = LOAD_STORE_IMM;
            6'b0111??: cls = LOAD_STORE_BYTE;
            6'b1000??: cls = LOAD_STORE_HW;
            6'b1001??: cls = LOAD_STORE_SP_R;
            6'b1011??: cls = MISC_16;
            6'b11000?: cls = STORE_MULT;
            6'b11001?: cls = LOAD_MULT;
            default:   cls = CLASS_OTHER;
        endcase
        return cls;
    endfunction

    function automatic shift_code_e shift_code_of(input logic [4:0] code);
        // only the 011 prefix uses all five bits as opcode
        if (code[4:2] == 3'b011) begin
            return shift_code_e'(code);
        end
        return shift_code_e'({code[4:2], 2'b00});
    endfunction

    function automatic misc_code_e misc_code_of(input logic [6:0] code);
        misc_code_e mc;
        casez (code)
            7'b010????: mc = PUSH_REGS;
            7'b110????: mc = POP_REGS;
            default:    mc = MISC_OTHER;
        endcase
        return mc;
    endfunction

endpackage

`default_nettype wire

//--- thumb_ctrl_pkg.sv
`default_nettype none

`include "thumb_ctrl_cfg.svh"

package thumb_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD       = 4'd0,
        ALU_SUB       = 4'd1,
        ALU_AND       = 4'd2,
        ALU_OR        = 4'd3,
        ALU_XOR       = 4'd4,
        ALU_BIT_CLEAR = 4'd5,
        ALU_NOT       = 4'd6,
        ALU_MULT      = 4'd7,
        ALU_LSL       = 4'd8,
        ALU_LSR       = 4'd9,
        ALU_ASR       = 4'd10,
        ALU_ROR       = 4'd11
    } alu_op_e;

    typedef enum logic [1:0] {
        FROM_REG    = 2'd0,
        FROM_IMM    = 2'd1,
        FROM_ZERO   = 2'd2,
        FROM_OFFSET = 2'd3
    } operand_src_e;

    typedef struct packed {
        alu_op_e                alu_op;
        operand_src_e           src1;
        operand_src_e           src2;
        logic                   flag_update;
        logic                   reg_we;
        logic                   mem_we;
        logic                   mem_re;
        // destination register taken from reg_addr instead of the instruction
        logic                   dest_from_ctrl;
        // second read port addressed by reg_addr instead of the instruction
        logic                   src2_from_ctrl;
        logic [`REG_ADDR_W-1:0] reg_addr;
        logic [`WORD_W-1:0]     offset;
    } ctrl_word_t;

    // register add, nothing written
    localparam ctrl_word_t CTRL_IDLE = '{
        alu_op:         ALU_ADD,
        src1:           FROM_REG,
        src2:           FROM_REG,
        flag_update:    1'b0,
        reg_we:         1'b0,
        mem_we:         1'b0,
        mem_re:         1'b0,
        dest_from_ctrl: 1'b0,
        src2_from_ctrl: 1'b0,
        reg_addr:       '0,
        offset:         '0
    };

endpackage

`default_nettype wire

//--- thumb_instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module thumb_instr_decoder
    import thumb_isa_pkg::*;
    import thumb_ctrl_pkg::*;
(
    input  thumb_instr_u instruction_i,
    output ctrl_word_t   ctrl_o
);

    op_class_e   op_class;
    shift_code_e shift_code;
    dp_code_e    dp_code;
    logic        ls_reg_load;
    logic        ls_imm_load;

    assign op_class   = classify_op(instruction_i.opnd.op);
    // bits 13:9
    assign shift_code = shift_code_of({instruction_i.opnd.op[3:0],
                                       instruction_i.opnd.sub_code[3]});
    assign dp_code    = dp_code_e'(instruction_i.opnd.sub_code);

    // register offset opcode in bits 11:9, loads are 1xx and x11
    assign ls_reg_load = instruction_i.opnd.op[1] ||
                         (instruction_i.opnd.op[0] && instruction_i.opnd.sub_code[3]);
    assign ls_imm_load = instruction_i.opnd.op[1];

    always_comb begin
        ctrl_o = CTRL_IDLE;
        case (op_class)
            SHIFT_IMM: begin
                ctrl_o.flag_update = 1'b1;
                ctrl_o.reg_we      = 1'b1;
                case (shift_code)
                    LSL_IMM: begin
                        ctrl_o.alu_op = ALU_LSL;
                        ctrl_o.src2   = FROM_IMM;
                    end
                    LSR_IMM: begin
                        ctrl_o.alu_op = ALU_LSR;
                        ctrl_o.src2   = FROM_IMM;
                    end
                    ASR_IMM: begin
                        ctrl_o.alu_op = ALU_ASR;
                        ctrl_o.src2   = FROM_IMM;
                    end
                    ADD_REG: ctrl_o.alu_op = ALU_ADD;
                    SUB_REG: ctrl_o.alu_op = ALU_SUB;
                    ADD_3_IMM, ADD_8_IMM: ctrl_o.src2 = FROM_IMM;
                    SUB_3_IMM, SUB_8_IMM: begin
                        ctrl_o.alu_op = ALU_SUB;
                        ctrl_o.src2   = FROM_IMM;
                    end
                    // mov is 0 + imm8
                    MOV_8_IMM: begin
                        ctrl_o.src1 = FROM_ZERO;
                        ctrl_o.src2 = FROM_IMM;
                    end
                    CMP_8_IMM: begin
                        ctrl_o.alu_op = ALU_SUB;
                        ctrl_o.src2   = FROM_IMM;
                        ctrl_o.reg_we = 1'b0;
                    end
                    default: ;
                endcase
            end
            DATA_PROC: begin
                ctrl_o.flag_update = 1'b1;
                ctrl_o.reg_we      = 1'b1;
                case (dp_code)
                    DP_AND: ctrl_o.alu_op = ALU_AND;
                    DP_EOR: ctrl_o.alu_op = ALU_XOR;
                    DP_LSL: ctrl_o.alu_op = ALU_LSL;
                    DP_LSR: ctrl_o.alu_op = ALU_LSR;
                    DP_ASR: ctrl_o.alu_op = ALU_ASR;
                    // carry in is handled by the ALU from the flags
                    DP_ADC: ctrl_o.alu_op = ALU_ADD;
                    DP_SBC: ctrl_o.alu_op = ALU_SUB;
                    DP_ROR: ctrl_o.alu_op = ALU_ROR;
                    DP_TST: begin
                        ctrl_o.alu_op = ALU_AND;
                        ctrl_o.reg_we = 1'b0;
                    end
                    DP_RSB: begin
                        ctrl_o.alu_op = ALU_SUB;
                        ctrl_o.src1   = FROM_ZERO;
                    end
                    DP_CMP: begin
                        ctrl_o.alu_op = ALU_SUB;
                        ctrl_o.reg_we = 1'b0;
                    end
                    DP_CMN: begin
                        ctrl_o.alu_op = ALU_ADD;
                        ctrl_o.reg_we = 1'b0;
                    end
                    DP_ORR: ctrl_o.alu_op = ALU_OR;
                    DP_MUL: ctrl_o.alu_op = ALU_MULT;
                    DP_BIC: ctrl_o.alu_op = ALU_BIT_CLEAR;
                    DP_MVN: ctrl_o.alu_op = ALU_NOT;
                    default: ;
                endcase
            end
            LOAD_STORE_REG: begin
                if (ls_reg_load) begin
                    ctrl_o.reg_we = 1'b1;
                    ctrl_o.mem_re = 1'b1;
                end else begin
                    ctrl_o.mem_we = 1'b1;
                end
            end
            LOAD_STORE_IMM, LOAD_STORE_BYTE, LOAD_STORE_HW, LOAD_STORE_SP_R: begin
                ctrl_o.src2 = FROM_IMM;
                if (ls_imm_load) begin
                    ctrl_o.reg_we = 1'b1;
                    ctrl_o.mem_re = 1'b1;
                end else begin
                    ctrl_o.mem_we = 1'b1;
                end
            end
            // list classes are built by the sequencer
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- reg_list_picker.sv
`timescale 1ns/1ps
`default_nettype none

`include "thumb_ctrl_cfg.svh"

module reg_list_picker (
    input  logic [`LIST_W-1:0]     pending_i,
    output logic [`REG_ADDR_W-1:0] low_idx_o,
    output logic [`REG_ADDR_W-1:0] high_idx_o,
    output logic [`CNT_W-1:0]      pending_cnt_o
);

    always_comb begin
        low_idx_o     = '0;
        high_idx_o    = '0;
        pending_cnt_o = '0;

        // scanning downwards leaves the lowest set bit
        for (int i = `LIST_W - 1; i >= 0; i--) begin
            if (pending_i[i]) begin
                low_idx_o = `REG_ADDR_W'(i);
            end
        end

        // scanning upwards leaves the highest set bit
        for (int i = 0; i < `LIST_W; i++) begin
            if (pending_i[i]) begin
                high_idx_o    = `REG_ADDR_W'(i);
                pending_cnt_o = pending_cnt_o + 1'b1;
            end
        end

        if (pending_i != '0) begin
            assert (low_idx_o <= high_idx_o)
                else $error("picker: low index above high index");
        end
    end

endmodule

`default_nettype wire

//--- multi_reg_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "thumb_ctrl_cfg.svh"

module multi_reg_sequencer
    import thumb_isa_pkg::*;
    import thumb_ctrl_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_i,
    input  thumb_instr_u instruction_i,
    input  ctrl_word_t   dec_ctrl_i,
    output ctrl_word_t   ctrl_o,
    output logic         stall_o
);

    localparam logic [`REG_ADDR_W-1:0] SP_ADDR = `REG_ADDR_W'(`SP_REG_NUM);
    localparam logic [`WORD_W-1:0] WORD_BYTES = `WORD_W'(`BYTES_PER_WORD);

    op_class_e              op_class;
    misc_code_e             misc_code;
    logic                   is_push;
    logic                   is_pop;
    logic                   is_stm;
    logic                   is_ldm;
    logic                   is_list;
    logic [`LIST_W-1:0]     pending_mask;
    logic [`LIST_W-1:0]     pending;
    logic [`CNT_W-1:0]      beat_cnt;
    logic [`CNT_W-1:0]      pending_cnt;
    logic [`CNT_W-1:0]      total_cnt;
    logic                   base_in_list;
    logic [`REG_ADDR_W-1:0] low_idx;
    logic [`REG_ADDR_W-1:0] high_idx;
    logic [`REG_ADDR_W-1:0] pick_idx;
    logic [`REG_ADDR_W-1:0] base_addr;
    logic [`WORD_W-1:0]     total_bytes;
    logic [`WORD_W-1:0]     beat_bytes;

    assign op_class  = classify_op(instruction_i.opnd.op);
    // bits 11:5
    assign misc_code = misc_code_of({instruction_i.lst.load, instruction_i.lst.base,
                                     instruction_i.lst.reg_list[7:5]});

    assign is_push = (op_class == MISC_16) && (misc_code == PUSH_REGS);
    assign is_pop  = (op_class == MISC_16) && (misc_code == POP_REGS);
    assign is_stm  = (op_class == STORE_MULT);
    assign is_ldm  = (op_class == LOAD_MULT);
    assign is_list = is_push || is_pop || is_stm || is_ldm;

    assign pending   = instruction_i.lst.reg_list & pending_mask;
    assign base_addr = `REG_ADDR_W'(instruction_i.lst.base);

    reg_list_picker u_picker (
        .pending_i     (pending),
        .low_idx_o     (low_idx),
        .high_idx_o    (high_idx),
        .pending_cnt_o (pending_cnt)
    );

    // ldm fills from the top register down
    assign pick_idx = is_ldm ? high_idx : low_idx;

    // done beats plus remaining ones stays equal to the list size
    assign total_cnt   = beat_cnt + pending_cnt;
    assign total_bytes = `WORD_W'(total_cnt) * WORD_BYTES;
    assign beat_bytes  = `WORD_W'(beat_cnt) * WORD_BYTES;

    assign stall_o = is_list && (pending_cnt != '0);

    always_ff @(posedge clk_i) begin
        if (reset_i || !stall_o) begin
            beat_cnt     <= '0;
            pending_mask <= '1;
            base_in_list <= 1'b0;
        end else begin
            beat_cnt     <= beat_cnt + 1'b1;
            pending_mask <= pending_mask & ~(`LIST_W'(1) << pick_idx);
            if (pick_idx == base_addr) begin
                base_in_list <= 1'b1;
            end
        end
    end

    always_comb begin
        ctrl_o = dec_ctrl_i;
        if (is_list) begin
            ctrl_o.alu_op = ALU_ADD;
            ctrl_o.src2   = FROM_OFFSET;
            if (stall_o) begin
                ctrl_o.reg_addr = pick_idx;
                if (is_push || is_stm) begin
                    ctrl_o.mem_we         = 1'b1;
                    ctrl_o.src2_from_ctrl = 1'b1;
                    if (is_push) begin
                        // lowest register lands at SP - 4N
                        ctrl_o.alu_op = ALU_SUB;
                        ctrl_o.offset = total_bytes - beat_bytes;
                    end else begin
                        ctrl_o.offset = beat_bytes;
                    end
                end else begin
                    ctrl_o.reg_we         = 1'b1;
                    ctrl_o.mem_re         = 1'b1;
                    ctrl_o.dest_from_ctrl = 1'b1;
                    if (is_ldm) begin
                        ctrl_o.offset = total_bytes - WORD_BYTES - beat_bytes;
                    end else begin
                        ctrl_o.offset = beat_bytes;
                    end
                end
            end else begin
                // final beat, write back SP or the base register
                ctrl_o.offset         = total_bytes;
                ctrl_o.dest_from_ctrl = 1'b1;
                ctrl_o.reg_addr       = (is_push || is_pop) ? SP_ADDR : base_addr;
                ctrl_o.reg_we         = !(is_ldm && base_in_list);
                if (is_push) begin
                    ctrl_o.alu_op = ALU_SUB;
                end
            end
        end
    end

    // a list holds at most LIST_W registers, so no more than LIST_W stall cycles in a row
    assert property (@(posedge clk_i) disable iff (reset_i)
        stall_o |-> (beat_cnt < `CNT_W'(`LIST_W)))
        else $error("sequencer: stall held past the list length");

    // decode and sequencing must never mix a memory write with a register write
    assert property (@(posedge clk_i) disable iff (reset_i)
        !(ctrl_o.mem_we && ctrl_o.reg_we))
        else $error("sequencer: mem_we and reg_we both set");

endmodule

`default_nettype wire

//--- thumb_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module thumb_ctrl_top
    import thumb_isa_pkg::*;
    import thumb_ctrl_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_i,
    input  thumb_instr_u instruction_i,
    output ctrl_word_t   ctrl_o,
    output logic         stall_o
);

    ctrl_word_t dec_ctrl;

    thumb_instr_decoder u_decoder (
        .instruction_i (instruction_i),
        .ctrl_o        (dec_ctrl)
    );

    // overrides the decoded word during PUSH, POP, STM and LDM
    multi_reg_sequencer u_sequencer (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instruction_i (instruction_i),
        .dec_ctrl_i    (dec_ctrl),
        .ctrl_o        (ctrl_o),
        .stall_o       (stall_o)
    );

endmodule

`default_nettype wire

//--- tb_thumb_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "thumb_ctrl_cfg.svh"

module tb_thumb_ctrl
    import thumb_isa_pkg::*;
    import thumb_ctrl_pkg::*;
();

    localparam int MAX_BEATS = `LIST_W + 1;
    localparam int N_SHIFT   = 32;
    localparam int N_DP      = 200;
    localparam int N_LS      = 100;
    localparam int N_LIST    = 40;
    localparam int N_PAIRS   = 20;
    // two resets, one idle cycle per test, every test at its longest, then margin
    localparam int CYCLE_LIMIT = 2 * 5 + 6 + N_SHIFT + N_DP + N_LS
                                 + 2 * N_LIST * MAX_BEATS + N_PAIRS * (MAX_BEATS + 1)
                                 + MAX_BEATS + 5 + 100;

    typedef struct packed {
        ctrl_word_t ctrl;
        logic       stall;
    } expect_t;

    logic         clk_i;
    logic         reset_i;
    thumb_instr_u instr_q;
    ctrl_word_t   ctrl_o;
    logic         stall_o;

    int      beat_q;
    logic    check_en;
    integer  seed;
    int      cycle_count   = 0;
    int      check_count   = 0;
    int      error_count   = 0;
    int      test_err_base = 0;
    int      tests_run     = 0;
    int      tests_failed  = 0;
    expect_t exp_word;
    expect_t got_word;

    thumb_ctrl_top DUT (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instruction_i (instr_q),
        .ctrl_o        (ctrl_o),
        .stall_o       (stall_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // k-th listed register, counted from the bottom or from the top
    function automatic int pick_register(input logic [7:0] list, input int k, input bit from_top);
        int seen;
        int idx;
        int pos;
        seen = 0;
        idx  = 0;
        for (int i = 0; i < `LIST_W; i++) begin
            pos = from_top ? (`LIST_W - 1 - i) : i;
            if (list[pos]) begin
                if (seen == k) begin
                    idx = pos;
                end
                seen++;
            end
        end
        return idx;
    endfunction

    function automatic expect_t expected_ctrl(input logic [15:0] instr, input int beat);
        expect_t    e;
        logic [7:0] list;
        logic [2:0] base;
        logic       push, pop, stm, ldm, load;
        int         n;
        e    = '0;
        list = instr[7:0];
        base = instr[10:8];
        push = (instr[15:9] == 7'b1011010);
        pop  = (instr[15:9] == 7'b1011110);
        stm  = (instr[15:11] == 5'b11000);
        ldm  = (instr[15:11] == 5'b11001);
        n    = $countones(list);
        if (push || pop || stm || ldm) begin
            e.ctrl.src2 = FROM_OFFSET;
            if (beat < n) begin
                e.stall         = 1'b1;
                e.ctrl.reg_addr = `REG_ADDR_W'(pick_register(list, beat, ldm));
                if (push || stm) begin
                    e.ctrl.mem_we         = 1'b1;
                    e.ctrl.src2_from_ctrl = 1'b1;
                end else begin
                    e.ctrl.reg_we         = 1'b1;
                    e.ctrl.mem_re         = 1'b1;
                    e.ctrl.dest_from_ctrl = 1'b1;
                end
                if (push) begin
                    e.ctrl.alu_op = ALU_SUB;
                    e.ctrl.offset = `WORD_W'(`BYTES_PER_WORD * (n - beat));
                end else if (ldm) begin
                    e.ctrl.offset = `WORD_W'(`BYTES_PER_WORD * (n - 1 - beat));
                end else begin
                    e.ctrl.offset = `WORD_W'(`BYTES_PER_WORD * beat);
                end
            end else begin
                // write back of SP or the base register
                e.ctrl.alu_op         = push ? ALU_SUB : ALU_ADD;
                e.ctrl.offset         = `WORD_W'(`BYTES_PER_WORD * n);
                e.ctrl.dest_from_ctrl = 1'b1;
                e.ctrl.reg_addr       = (push || pop) ? `REG_ADDR_W'(`SP_REG_NUM) : {1'b0, base};
                e.ctrl.reg_we         = !(ldm && list[base]);
            end
        end else if (instr[15:14] == 2'b00) begin
            e.ctrl.flag_update = 1'b1;
            e.ctrl.reg_we      = 1'b1;
            e.ctrl.src2        = FROM_IMM;
            case (instr[13:11])
                3'b000: e.ctrl.alu_op = ALU_LSL;
                3'b001: e.ctrl.alu_op = ALU_LSR;
                3'b010: e.ctrl.alu_op = ALU_ASR;
                // bit 10 selects imm3 over a register, bit 9 selects subtract
                3'b011: begin
                    e.ctrl.src2   = instr[10] ? FROM_IMM : FROM_REG;
                    e.ctrl.alu_op = instr[9] ? ALU_SUB : ALU_ADD;
                end
                3'b100: e.ctrl.src1 = FROM_ZERO;
                3'b101: begin
                    e.ctrl.alu_op = ALU_SUB;
                    e.ctrl.reg_we = 1'b0;
                end
                3'b111: e.ctrl.alu_op = ALU_SUB;
                default: ;
            endcase
        end else if (instr[15:10] == 6'b010000) begin
            e.ctrl.flag_update = 1'b1;
            e.ctrl.reg_we      = 1'b1;
            case (instr[9:6])
                4'h0, 4'h8:       e.ctrl.alu_op = ALU_AND;
                4'h1:             e.ctrl.alu_op = ALU_XOR;
                4'h2:             e.ctrl.alu_op = ALU_LSL;
                4'h3:             e.ctrl.alu_op = ALU_LSR;
                4'h4:             e.ctrl.alu_op = ALU_ASR;
                4'h5, 4'hb:       e.ctrl.alu_op = ALU_ADD;
                4'h6, 4'h9, 4'ha: e.ctrl.alu_op = ALU_SUB;
                4'h7:             e.ctrl.alu_op = ALU_ROR;
                4'hc:             e.ctrl.alu_op = ALU_OR;
                4'hd:             e.ctrl.alu_op = ALU_MULT;
                4'he:             e.ctrl.alu_op = ALU_BIT_CLEAR;
                default:          e.ctrl.alu_op = ALU_NOT;
            endcase
            // tst, cmp and cmn only set flags
            if (instr[9:6] == 4'h8 || instr[9:6] == 4'ha || instr[9:6] == 4'hb) begin
                e.ctrl.reg_we = 1'b0;
            end
            // rsb computes 0 - rm
            if (instr[9:6] == 4'h9) begin
                e.ctrl.src1 = FROM_ZERO;
            end
        end else if (instr[15:12] >= 4'h5 && instr[15:12] <= 4'h9) begin
            if (instr[15:12] == 4'h5) begin
                load = instr[11] || (instr[10] && instr[9]);
            end else begin
                e.ctrl.src2 = FROM_IMM;
                load        = instr[11];
            end
            e.ctrl.reg_we = load;
            e.ctrl.mem_re = load;
            e.ctrl.mem_we = !load;
        end
        return e;
    endfunction

    always @(negedge clk_i) begin
        if (check_en) begin
            exp_word       = expected_ctrl(instr_q, beat_q);
            got_word.ctrl  = ctrl_o;
            got_word.stall = stall_o;
            check_count++;
            assert (got_word == exp_word)
                else begin
                    error_count++;
                    $display("FAILED %0t ns: instr %h beat %0d got %h/%b exp %h/%b",
                             $time, instr_q, beat_q, got_word.ctrl, got_word.stall,
                             exp_word.ctrl, exp_word.stall);
                end
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("timeout: no result after %0d clock cycles, stall_o may be stuck high",
                 CYCLE_LIMIT);
        $display("Result: FAILED");
        $finish;
    end

    task automatic apply_reset();
        reset_i <= 1'b1;
        instr_q <= '0;
        beat_q  <= 0;
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
    endtask

    task automatic issue_single(input logic [15:0] instr);
        @(posedge clk_i);
        instr_q <= instr;
        beat_q  <= 0;
    endtask

    // held until the sequencer drops stall_o on the final beat
    task automatic issue_list(input logic [15:0] instr);
        @(posedge clk_i);
        instr_q <= instr;
        beat_q  <= 0;
        @(negedge clk_i);
        while (stall_o) begin
            @(posedge clk_i);
            beat_q <= beat_q + 1;
            @(negedge clk_i);
        end
    endtask

    // a reset in the middle of a push restarts it from the first register
    task automatic reset_mid_list();
        issue_single({7'b1011010, 1'b0, 8'hff});
        repeat (4) begin
            @(posedge clk_i);
            beat_q <= beat_q + 1;
        end
        // the sequencer still shows beat 4 until it samples reset on the next edge
        reset_i <= 1'b1;
        @(posedge clk_i);
        reset_i <= 1'b0;
        beat_q  <= 0;
        @(negedge clk_i);
        while (stall_o) begin
            @(posedge clk_i);
            beat_q <= beat_q + 1;
            @(negedge clk_i);
        end
    endtask

    task automatic end_test(input string name);
        @(posedge clk_i);
        instr_q <= '0;
        beat_q  <= 0;
        tests_run++;
        if (error_count == test_err_base) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, error_count - test_err_base);
        end
        test_err_base = error_count;
    endtask

    task automatic shift_group_test();
        int rnd;
        for (int code = 0; code < N_SHIFT; code++) begin
            rnd = $random(seed);
            issue_single({2'b00, 5'(code), rnd[8:0]});
        end
    endtask

    task automatic data_proc_test();
        int rnd;
        for (int i = 0; i < N_DP; i++) begin
            rnd = $random(seed);
            issue_single({6'b010000, rnd[9:0]});
        end
    endtask

    task automatic load_store_test();
        logic [3:0] top_nibble [5];
        int         rnd;
        int         sel;
        top_nibble = '{4'h5, 4'h6, 4'h7, 4'h8, 4'h9};
        for (int i = 0; i < N_LS; i++) begin
            rnd = $random(seed);
            sel = (rnd & 32'h7fff_ffff) % 5;
            issue_single({top_nibble[sel], rnd[11:0]});
        end
    endtask

    task automatic store_list_test();
        int         rnd;
        logic [7:0] list;
        for (int i = 0; i < N_LIST; i++) begin
            rnd = $random(seed);
            // the first push and the first stm run with an empty list
            list = (i < 2) ? 8'h00 : rnd[7:0];
            if (i % 2 == 0) begin
                issue_list({7'b1011010, 1'b0, list});
            end else begin
                issue_list({5'b11000, rnd[10:8], list});
            end
        end
    endtask

    task automatic load_list_test();
        int         rnd;
        logic [7:0] list;
        for (int i = 0; i < N_LIST; i++) begin
            rnd  = $random(seed);
            list = rnd[7:0];
            // ldm base forced into the list once and out of it once
            if (i == 1) begin
                list = list | (8'h01 << rnd[10:8]);
            end
            if (i == 3) begin
                list = list & ~(8'h01 << rnd[10:8]);
            end
            if (i % 2 == 0) begin
                issue_list({7'b1011110, 1'b0, list});
            end else begin
                issue_list({5'b11001, rnd[10:8], list});
            end
        end
    endtask

    task automatic back_to_back_test();
        int rnd;
        apply_reset();
        reset_mid_list();
        for (int i = 0; i < N_PAIRS; i++) begin
            rnd = $random(seed);
            case (i % 4)
                0:       issue_list({7'b1011010, 1'b0, rnd[7:0]});
                1:       issue_list({7'b1011110, 1'b0, rnd[7:0]});
                2:       issue_list({5'b11000, rnd[10:8], rnd[7:0]});
                default: issue_list({5'b11001, rnd[10:8], rnd[7:0]});
            endcase
            issue_single({6'b010000, rnd[19:10]});
        end
    endtask

    initial begin
        seed     = 32'hca8a_0e15;
        check_en <= 1'b0;
        apply_reset();
        check_en <= 1'b1;
        shift_group_test();
        end_test("shift/immediate group");
        data_proc_test();
        end_test("data-processing group");
        load_store_test();
        end_test("single-register load/store");
        store_list_test();
        end_test("push and stm");
        load_list_test();
        end_test("pop and ldm");
        back_to_back_test();
        end_test("back-to-back");
        $display("tests: %0d run, %0d failed, checks: %0d, errors: %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- thumb_ctrl_top.f
+incdir+.
thumb_isa_pkg.sv
thumb_ctrl_pkg.sv
thumb_instr_decoder.sv
reg_list_picker.sv
multi_reg_sequencer.sv
thumb_ctrl_top.sv
tb_thumb_ctrl.sv

//--- Makefile
# Verilator simulation of the thumb control unit

VERILATOR ?= verilator
TOP       ?= tb_thumb_ctrl
FILELIST  ?= thumb_ctrl_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "variables:  VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
